// File: rtl/gf3_pkg.sv
package gf3_pkg;

    localparam int M = 97;
    localparam int TAP = 12;  // middle term of x^97 + x^12 + 2

    typedef logic [1:0] gf3_digit_t;  // 00=0, 01=1, 10=2
    typedef logic [2*M-1:0] gf3m_t;

    localparam gf3m_t gf3m_zero = '0;
    localparam gf3m_t gf3m_one = gf3m_t'(1);

    function automatic gf3_digit_t f3_add(gf3_digit_t a, gf3_digit_t b);
        logic [2:0] s;
        s = 3'(a) + 3'(b);
        if (s >= 3'd3)
            s = s - 3'd3;
        return s[1:0];
    endfunction

    function automatic gf3_digit_t f3_neg(gf3_digit_t a);
        return {a[0], a[1]};  // 1 <-> 2
    endfunction

    function automatic gf3_digit_t f3_sub(gf3_digit_t a, gf3_digit_t b);
        return f3_add(a, f3_neg(b));
    endfunction

    function automatic gf3_digit_t f3_mul(gf3_digit_t a, gf3_digit_t b);
        return {(a[1] & b[0]) | (a[0] & b[1]), (a[0] & b[0]) | (a[1] & b[1])};
    endfunction

    function automatic gf3m_t gf3m_add(gf3m_t a, gf3m_t b);
        gf3m_t r;
        for (int i = 0; i < M; i++)
            r[2*i +: 2] = f3_add(a[2*i +: 2], b[2*i +: 2]);
        return r;
    endfunction

    function automatic gf3m_t gf3m_neg(gf3m_t a);
        gf3m_t r;
        for (int i = 0; i < M; i++)
            r[2*i +: 2] = f3_neg(a[2*i +: 2]);
        return r;
    endfunction

    function automatic gf3m_t gf3m_sub(gf3m_t a, gf3m_t b);
        return gf3m_add(a, gf3m_neg(b));
    endfunction

    function automatic gf3m_t gf3m_scale(gf3m_t a, gf3_digit_t k);
        gf3m_t r;
        for (int i = 0; i < M; i++)
            r[2*i +: 2] = f3_mul(a[2*i +: 2], k);
        return r;
    endfunction

    // a*x mod p, folding x^M back as 2x^TAP + 1
    function automatic gf3m_t gf3m_mul_x(gf3m_t a);
        gf3m_t r;
        gf3_digit_t t;
        t = a[2*M-1 -: 2];
        r = {a[2*M-3:0], 2'b00};
        r[1:0] = t;
        r[2*TAP +: 2] = f3_sub(r[2*TAP +: 2], t);
        return r;
    endfunction

endpackage

// File: rtl/tower_if.sv
`timescale 1ns/1ns

interface tower_if;
    gf3_pkg::gf3m_t e0;
    gf3_pkg::gf3m_t e1;
    gf3_pkg::gf3m_t e2;
    logic valid;  // one-cycle pulse, e0..e2 held until the next one

    modport src (
        output e0, e1, e2, valid
    );

    modport dst (
        input e0, e1, e2, valid
    );
endinterface

// File: rtl/gf3m_mult.sv
`timescale 1ns/1ns

module gf3m_mult #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  gf3_pkg::gf3m_t x,
    input  gf3_pkg::gf3m_t y,
    output gf3_pkg::gf3m_t p,
    output logic           done
);
    localparam int STEPS = (gf3_pkg::M + DIGITS - 1) / DIGITS;
    localparam int CW = $clog2(STEPS + 1);

    gf3_pkg::gf3m_t xs, ys, acc;
    gf3_pkg::gf3m_t xs_next, acc_next;
    logic [CW-1:0] cnt;
    logic run;

    // DIGITS low digits of y into the accumulator, x advanced by x^DIGITS
    always_comb
    begin
        xs_next = xs;
        acc_next = acc;
        for (int j = 0; j < DIGITS; j++)
        begin
            acc_next = gf3_pkg::gf3m_add(acc_next, gf3_pkg::gf3m_scale(xs_next, ys[2*j +: 2]));
            xs_next = gf3_pkg::gf3m_mul_x(xs_next);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !run)
            begin
                run <= 1'b1;
                cnt <= CW'(STEPS);
            end
            else if (run && cnt != '0)
                cnt <= cnt - 1'b1;
            else if (run)
            begin
                run <= 1'b0;  // result cycle
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && !run)
        begin
            xs <= x;
            ys <= y;
            acc <= gf3_pkg::gf3m_zero;
        end
        else if (run && cnt != '0)
        begin
            xs <= xs_next;
            ys <= ys >> (2*DIGITS);
            acc <= acc_next;
        end
        if (run && cnt == '0)
            p <= acc;
    end
endmodule

// File: rtl/gf3m_triple_mult.sv
`timescale 1ns/1ns

module gf3m_triple_mult #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  gf3_pkg::gf3m_t x0,
    input  gf3_pkg::gf3m_t y0,
    input  gf3_pkg::gf3m_t x1,
    input  gf3_pkg::gf3m_t y1,
    input  gf3_pkg::gf3m_t x2,
    input  gf3_pkg::gf3m_t y2,
    output gf3_pkg::gf3m_t p0,
    output gf3_pkg::gf3m_t p1,
    output gf3_pkg::gf3m_t p2,
    output logic           done
);
    logic [2:0] phase, sel;
    logic idle, m_start, m_done;
    gf3_pkg::gf3m_t mx, my, mp;

    assign idle = (phase == 3'b000);
    // the next pair is steered in during the cycle the last product is presented
    assign sel = idle ? 3'b001 : (m_done ? {phase[1:0], 1'b0} : phase);
    assign m_start = (start && idle) || (m_done && !phase[2]);

    always_comb
    begin
        mx = x0;
        my = y0;
        if (sel[1])
        begin
            mx = x1;
            my = y1;
        end
        else if (sel[2])
        begin
            mx = x2;
            my = y2;
        end
    end

    gf3m_mult #(.DIGITS(DIGITS)) u_mult (
        .clk   (clk),
        .reset (reset),
        .start (m_start),
        .x     (mx),
        .y     (my),
        .p     (mp),
        .done  (m_done)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= 3'b000;
            done <= 1'b0;
        end
        else
        begin
            done <= m_done && phase[2];
            if (start && idle)
                phase <= 3'b001;
            else if (m_done)
                phase <= {phase[1:0], 1'b0};  // falls to idle after the third
        end
    end

    always_ff @(posedge clk)
    begin
        if (m_done && phase[0])
            p0 <= mp;
        if (m_done && phase[1])
            p1 <= mp;
        if (m_done && phase[2])
            p2 <= mp;
    end
endmodule

// File: rtl/gf3m_inv.sv
`timescale 1ns/1ns

module gf3m_inv (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  gf3_pkg::gf3m_t a,
    output gf3_pkg::gf3m_t c,
    output logic           done
);
    localparam int M = gf3_pkg::M;
    localparam int TAP = gf3_pkg::TAP;
    localparam int W = 2*M + 2;  // one extra digit for the leading term
    localparam int CW = $clog2(2*M + 1);

    typedef logic [W-1:0] poly_t;

    localparam poly_t P = (poly_t'(1) << (2*M)) | (poly_t'(1) << (2*TAP)) | poly_t'(2);

    poly_t s, r, s_red;
    gf3_pkg::gf3m_t u, v, v_red;
    logic [2*M:0] d;  // one-hot distance, bit 0 means zero
    logic [CW-1:0] cnt;
    logic run;
    gf3_pkg::gf3_digit_t q, r_top;

    function automatic poly_t sub_scaled(poly_t f, poly_t g, gf3_pkg::gf3_digit_t k);
        poly_t o;
        for (int i = 0; i <= M; i++)
            o[2*i +: 2] = gf3_pkg::f3_sub(f[2*i +: 2], gf3_pkg::f3_mul(g[2*i +: 2], k));
        return o;
    endfunction

    // e/x mod p, adds e0*p first so the constant term vanishes
    function automatic gf3_pkg::gf3m_t div_x(gf3_pkg::gf3m_t e);
        gf3_pkg::gf3m_t o;
        gf3_pkg::gf3_digit_t t;
        t = e[1:0];
        o = e >> 2;
        o[2*M-1 -: 2] = t;
        o[2*(TAP-1) +: 2] = gf3_pkg::f3_add(o[2*(TAP-1) +: 2], t);
        return o;
    endfunction

    assign r_top = r[W-1 -: 2];
    assign q = gf3_pkg::f3_mul(s[W-1 -: 2], r_top);  // s_m / r_m
    assign s_red = sub_scaled(s, r, q);
    assign v_red = gf3_pkg::gf3m_sub(v, gf3_pkg::gf3m_scale(u, q));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !run)
            begin
                run <= 1'b1;
                cnt <= CW'(2*M);
            end
            else if (run && cnt != '0)
                cnt <= cnt - 1'b1;
            else if (run)
            begin
                run <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && !run)
        begin
            s <= P;
            r <= poly_t'(a);
            u <= gf3_pkg::gf3m_one;
            v <= gf3_pkg::gf3m_zero;
            d <= (2*M+1)'(1);
        end
        else if (run && cnt != '0)
        begin
            if (r_top == 2'b00)
            begin
                r <= r << 2;
                u <= gf3_pkg::gf3m_mul_x(u);
                d <= d << 1;
            end
            else if (d[0])
            begin
                r <= s_red << 2;  // swap and reduce
                s <= r;
                u <= gf3_pkg::gf3m_mul_x(v_red);
                v <= u;
                d <= d << 1;
            end
            else
            begin
                s <= s_red << 2;
                v <= v_red;
                u <= div_x(u);
                d <= d >> 1;
            end
        end
        if (run && cnt == '0)
            c <= gf3_pkg::gf3m_scale(u, r_top);  // r_m is its own inverse
    end
endmodule

// File: rtl/tower_square_stage.sv
`timescale 1ns/1ns

module tower_square_stage #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  gf3_pkg::gf3m_t a0,
    input  gf3_pkg::gf3m_t a1,
    input  gf3_pkg::gf3m_t a2,
    tower_if.src           sq_if,
    tower_if.src           diff_if,
    tower_if.src           adj_if
);
    gf3_pkg::gf3m_t l0, l1, l2;
    gf3_pkg::gf3m_t o0, o1, o2;
    gf3_pkg::gf3m_t v0, v1, v2, x02, x01, x12;
    logic sq_done, cross_done, both_done;

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            l0 <= a0;
            l1 <= a1;
            l2 <= a2;
        end
    end

    // first pair is loaded on the start edge itself
    assign o0 = start ? a0 : l0;
    assign o1 = start ? a1 : l1;
    assign o2 = start ? a2 : l2;

    gf3m_triple_mult #(.DIGITS(DIGITS)) u_squares (
        .clk (clk), .reset (reset), .start (start),
        .x0 (o0), .y0 (o0), .x1 (o1), .y1 (o1), .x2 (o2), .y2 (o2),
        .p0 (v0), .p1 (v1), .p2 (v2), .done (sq_done)
    );

    gf3m_triple_mult #(.DIGITS(DIGITS)) u_cross (
        .clk (clk), .reset (reset), .start (start),
        .x0 (o0), .y0 (o2), .x1 (o0), .y1 (o1), .x2 (o1), .y2 (o2),
        .p0 (x02), .p1 (x01), .p2 (x12), .done (cross_done)
    );

    assign both_done = sq_done && cross_done;  // sequencers run in lockstep

    assign sq_if.e0 = v0;
    assign sq_if.e1 = v1;
    assign sq_if.e2 = v2;
    assign sq_if.valid = both_done;

    assign diff_if.e0 = gf3_pkg::gf3m_sub(l0, l2);
    assign diff_if.e1 = gf3_pkg::gf3m_sub(l1, l0);
    assign diff_if.e2 = gf3_pkg::gf3m_add(gf3_pkg::gf3m_sub(l0, l1), l2);
    assign diff_if.valid = both_done;

    assign adj_if.e0 = gf3_pkg::gf3m_add(gf3_pkg::gf3m_add(v0, v2),
        gf3_pkg::gf3m_neg(gf3_pkg::gf3m_add(gf3_pkg::gf3m_add(x02, v1), x12)));
    assign adj_if.e1 = gf3_pkg::gf3m_sub(v2, x01);
    assign adj_if.e2 = gf3_pkg::gf3m_sub(gf3_pkg::gf3m_sub(v1, x02), v2);
    assign adj_if.valid = both_done;
endmodule

// File: rtl/tower_norm_stage.sv
`timescale 1ns/1ns

module tower_norm_stage #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    tower_if.dst           sq_if,
    tower_if.dst           diff_if,
    tower_if.dst           adj_if,
    tower_if.src           adj_out,
    output gf3_pkg::gf3m_t norm,
    output logic           norm_valid
);
    gf3_pkg::gf3m_t t0, t1, t2;
    gf3_pkg::gf3m_t k0, k1, k2;
    logic prod_done;

    gf3m_triple_mult #(.DIGITS(DIGITS)) u_norm_mult (
        .clk (clk), .reset (reset), .start (sq_if.valid && diff_if.valid),
        .x0 (sq_if.e0), .y0 (diff_if.e0),
        .x1 (sq_if.e1), .y1 (diff_if.e1),
        .x2 (sq_if.e2), .y2 (diff_if.e2),
        .p0 (t0), .p1 (t1), .p2 (t2), .done (prod_done)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            norm_valid <= 1'b0;
        else
            norm_valid <= prod_done;
    end

    always_ff @(posedge clk)
    begin
        if (prod_done)
            norm <= gf3_pkg::gf3m_add(gf3_pkg::gf3m_add(t0, t1), t2);
        if (adj_if.valid)
        begin
            k0 <= adj_if.e0;
            k1 <= adj_if.e1;
            k2 <= adj_if.e2;
        end
    end

    assign adj_out.e0 = k0;
    assign adj_out.e1 = k1;
    assign adj_out.e2 = k2;
    assign adj_out.valid = norm_valid;  // lines up with the norm
endmodule

// File: rtl/tower_scale_stage.sv
`timescale 1ns/1ns

module tower_scale_stage #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    tower_if.dst           adj_if,
    input  gf3_pkg::gf3m_t inv,
    input  logic           inv_valid,
    output gf3_pkg::gf3m_t c0,
    output gf3_pkg::gf3m_t c1,
    output gf3_pkg::gf3m_t c2,
    output logic           done
);
    gf3_pkg::gf3m_t k0, k1, k2;
    gf3_pkg::gf3m_t p0, p1, p2;
    logic prod_done;

    always_ff @(posedge clk)
    begin
        if (adj_if.valid)
        begin
            k0 <= adj_if.e0;
            k1 <= adj_if.e1;
            k2 <= adj_if.e2;
        end
        if (prod_done)
        begin
            c0 <= p0;  // held until the next operation
            c1 <= p1;
            c2 <= p2;
        end
    end

    gf3m_triple_mult #(.DIGITS(DIGITS)) u_scale_mult (
        .clk (clk), .reset (reset), .start (inv_valid),
        .x0 (inv), .y0 (k0), .x1 (inv), .y1 (k1), .x2 (inv), .y2 (k2),
        .p0 (p0), .p1 (p1), .p2 (p2), .done (prod_done)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= prod_done;
    end
endmodule

// File: rtl/gf3_tower_inv.sv
`timescale 1ns/1ns

module gf3_tower_inv #(
    parameter int DIGITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  gf3_pkg::gf3m_t a0,
    input  gf3_pkg::gf3m_t a1,
    input  gf3_pkg::gf3m_t a2,
    output gf3_pkg::gf3m_t c0,
    output gf3_pkg::gf3m_t c1,
    output gf3_pkg::gf3m_t c2,
    output logic           done,
    output logic           busy
);
    tower_if sq_if ();
    tower_if diff_if ();
    tower_if adj_if ();
    tower_if adj_fwd_if ();

    gf3_pkg::gf3m_t norm, norm_inv;
    logic norm_valid, inv_done, accept;

    assign accept = start && !busy;  // one operation in flight

    always_ff @(posedge clk)
    begin
        if (reset)
            busy <= 1'b0;
        else if (accept)
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;
    end

    tower_square_stage #(.DIGITS(DIGITS)) u_square (
        .clk (clk), .reset (reset), .start (accept), .a0 (a0), .a1 (a1), .a2 (a2),
        .sq_if (sq_if), .diff_if (diff_if), .adj_if (adj_if)
    );

    tower_norm_stage #(.DIGITS(DIGITS)) u_norm (
        .clk (clk), .reset (reset), .sq_if (sq_if), .diff_if (diff_if), .adj_if (adj_if),
        .adj_out (adj_fwd_if), .norm (norm), .norm_valid (norm_valid)
    );

    gf3m_inv u_inv (
        .clk (clk), .reset (reset), .start (norm_valid), .a (norm),
        .c (norm_inv), .done (inv_done)
    );

    tower_scale_stage #(.DIGITS(DIGITS)) u_scale (
        .clk (clk), .reset (reset), .adj_if (adj_fwd_if), .inv (norm_inv),
        .inv_valid (inv_done), .c0 (c0), .c1 (c1), .c2 (c2), .done (done)
    );
endmodule

// File: dv/gf3_tower_inv_props.sv
`timescale 1ns/1ns

module gf3_tower_inv_props (
    input logic           clk,
    input logic           reset,
    input logic           done,
    input logic           busy,
    input gf3_pkg::gf3m_t c0,
    input gf3_pkg::gf3m_t c1,
    input gf3_pkg::gf3m_t c2
);
    function automatic logic bad_digit(gf3_pkg::gf3m_t e);
        for (int i = 0; i < gf3_pkg::M; i++)
            if (e[2*i +: 2] == 2'b11)
                return 1'b1;
        return 1'b0;
    endfunction

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    result_digits_legal: assert property (@(posedge clk) disable iff (reset)
        done |-> !bad_digit(c0) && !bad_digit(c1) && !bad_digit(c2))
        else $error("result holds a digit encoded as 11");

    busy_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else $error("busy high when reset released");
endmodule

// File: dv/tb_gf3_tower_inv.sv
`timescale 1ns/1ns

module tb_gf3_tower_inv;

    localparam int M = gf3_pkg::M;
    localparam int TAP = gf3_pkg::TAP;
    localparam int RESET_CYCLES = 16;
    localparam int N_OPS = 40;
    localparam int OP_CYCLES = 1200;
    localparam int TIMEOUT = N_OPS * OP_CYCLES + RESET_CYCLES;
    localparam int N_BASE = 3;
    localparam int N_RAND = N_OPS - N_BASE - 3;  // a = 1 and a = rho plus the busy test

    logic clk;
    logic reset;
    logic start;
    gf3_pkg::gf3m_t a0, a1, a2;
    gf3_pkg::gf3m_t c0, c1, c2;
    logic done;
    logic busy;

    int cycles = 0;
    int done_count = 0;
    int ops = 0;
    bit failed = 1'b0;
    bit passed = 1'b0;

    gf3_tower_inv #(.DIGITS(3)) u_gf3_tower_inv (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .a0    (a0),
        .a1    (a1),
        .a2    (a2),
        .c0    (c0),
        .c1    (c1),
        .c2    (c2),
        .done  (done),
        .busy  (busy)
    );

    bind gf3_tower_inv gf3_tower_inv_props u_props (
        .clk (clk), .reset (reset), .done (done), .busy (busy),
        .c0 (c0), .c1 (c1), .c2 (c2)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (!reset && done)
            done_count = done_count + 1;
        if (cycles >= TIMEOUT)
        begin
            failed = 1'b1;
            $display("TEST FAILED");
            $fatal(1, "timeout: the DUT gave no result within %0d cycles", TIMEOUT);
        end
    end

    final
    begin
        if (!passed && !failed)
            $display("TEST FAILED");
    end

    task automatic check(input string name, input gf3_pkg::gf3m_t expected,
                         input gf3_pkg::gf3m_t got);
        if (expected !== got)
        begin
            failed = 1'b1;
            $display("FAILED %s expected %h got %h", name, expected, got);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic int dig(gf3_pkg::gf3m_t e, int i);
        return int'(e[2*i +: 2]);
    endfunction

    function automatic gf3_pkg::gf3m_t base_add(gf3_pkg::gf3m_t x, gf3_pkg::gf3m_t y);
        gf3_pkg::gf3m_t r;
        r = '0;
        for (int i = 0; i < M; i++)
            r[2*i +: 2] = 2'((dig(x, i) + dig(y, i)) % 3);
        return r;
    endfunction

    // schoolbook product folded down with x^M = 2x^TAP + 1
    function automatic gf3_pkg::gf3m_t base_mul(gf3_pkg::gf3m_t x, gf3_pkg::gf3m_t y);
        int prod [0:2*M-2];
        int t;
        gf3_pkg::gf3m_t r;
        for (int k = 0; k <= 2*M-2; k++)
            prod[k] = 0;
        for (int i = 0; i < M; i++)
            for (int j = 0; j < M; j++)
                prod[i+j] = (prod[i+j] + dig(x, i) * dig(y, j)) % 3;
        for (int k = 2*M-2; k >= M; k--)
        begin
            t = prod[k];
            prod[k-M+TAP] = (prod[k-M+TAP] + 2*t) % 3;
            prod[k-M] = (prod[k-M] + t) % 3;
        end
        r = '0;
        for (int i = 0; i < M; i++)
            r[2*i +: 2] = 2'(prod[i]);
        return r;
    endfunction

    // reduces with rho^3 = rho + 1 and rho^4 = rho^2 + rho
    function automatic void tower_mul(input gf3_pkg::gf3m_t x0, x1, x2, y0, y1, y2,
                                      output gf3_pkg::gf3m_t z0, z1, z2);
        gf3_pkg::gf3m_t d0, d1, d2, d3, d4;
        d0 = base_mul(x0, y0);
        d1 = base_add(base_mul(x0, y1), base_mul(x1, y0));
        d2 = base_add(base_add(base_mul(x0, y2), base_mul(x1, y1)), base_mul(x2, y0));
        d3 = base_add(base_mul(x1, y2), base_mul(x2, y1));
        d4 = base_mul(x2, y2);
        z0 = base_add(d0, d3);
        z1 = base_add(base_add(d1, d3), d4);
        z2 = base_add(d2, d4);
    endfunction

    function automatic gf3_pkg::gf3m_t rand_elem();
        gf3_pkg::gf3m_t e;
        e = '0;
        for (int i = 0; i < M; i++)
            e[2*i +: 2] = 2'($urandom % 3);
        return e;
    endfunction

    task automatic issue_start(input gf3_pkg::gf3m_t b0, b1, b2);
        @(posedge clk);
        start <= 1'b1;
        a0 <= b0;
        a1 <= b1;
        a2 <= b2;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(output gf3_pkg::gf3m_t r0, r1, r2);
        do
            @(negedge clk);
        while (!done);
        r0 = c0;
        r1 = c1;
        r2 = c2;
        ops = ops + 1;
    endtask

    task automatic check_inverse(input gf3_pkg::gf3m_t b0, b1, b2, r0, r1, r2);
        gf3_pkg::gf3m_t z0, z1, z2;
        tower_mul(b0, b1, b2, r0, r1, r2, z0, z1, z2);
        check("(c*a)_0", gf3_pkg::gf3m_t'(1), z0);
        check("(c*a)_1", gf3_pkg::gf3m_t'(0), z1);
        check("(c*a)_2", gf3_pkg::gf3m_t'(0), z2);
    endtask

    initial
    begin
        gf3_pkg::gf3m_t b0, b1, b2, x0, x1, x2, r0, r1, r2;
        void'($urandom(32'h6fde));
        reset = 1'b1;
        start = 1'b0;
        a0 = '0;
        a1 = '0;
        a2 = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        repeat (8)
        begin
            @(negedge clk);
            check("done", '0, gf3_pkg::gf3m_t'(done));
            check("busy", '0, gf3_pkg::gf3m_t'(busy));
        end

        // a = 1
        issue_start(gf3_pkg::gf3m_t'(1), '0, '0);
        wait_done(r0, r1, r2);
        check("c0", gf3_pkg::gf3m_t'(1), r0);
        check("c1", '0, r1);
        check("c2", '0, r2);

        // a = rho has inverse rho^2 - 1
        issue_start('0, gf3_pkg::gf3m_t'(1), '0);
        wait_done(r0, r1, r2);
        check("c0", gf3_pkg::gf3m_t'(2), r0);
        check("c1", '0, r1);
        check("c2", gf3_pkg::gf3m_t'(1), r2);

        for (int n = 0; n < N_BASE; n++)
        begin
            do
                b0 = rand_elem();
            while (b0 == '0);
            issue_start(b0, '0, '0);
            wait_done(r0, r1, r2);
            check("c1", '0, r1);
            check("c2", '0, r2);
            check("a0*c0", gf3_pkg::gf3m_t'(1), base_mul(b0, r0));
        end

        for (int n = 0; n < N_RAND; n++)
        begin
            do
            begin
                b0 = rand_elem();
                b1 = rand_elem();
                b2 = rand_elem();
            end
            while (b0 == '0 && b1 == '0 && b2 == '0);
            issue_start(b0, b1, b2);
            wait_done(r0, r1, r2);
            check_inverse(b0, b1, b2, r0, r1, r2);
        end

        // second start lands mid-operation and must be dropped
        b0 = rand_elem();
        b1 = rand_elem();
        b2 = gf3_pkg::gf3m_t'(1);
        x0 = rand_elem();
        x1 = gf3_pkg::gf3m_t'(2);
        x2 = rand_elem();
        issue_start(b0, b1, b2);
        repeat (20) @(negedge clk);
        check("busy", gf3_pkg::gf3m_t'(1), gf3_pkg::gf3m_t'(busy));
        issue_start(x0, x1, x2);
        wait_done(r0, r1, r2);
        check_inverse(b0, b1, b2, r0, r1, r2);
        repeat (OP_CYCLES) @(negedge clk);
        check("done_count", gf3_pkg::gf3m_t'(ops), gf3_pkg::gf3m_t'(done_count));

        if (!failed)
        begin
            passed = 1'b1;
            $display("TEST OK");
        end
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
rtl/gf3_pkg.sv
rtl/tower_if.sv
rtl/gf3m_mult.sv
rtl/gf3m_triple_mult.sv
rtl/gf3m_inv.sv
rtl/tower_square_stage.sv
rtl/tower_norm_stage.sv
rtl/tower_scale_stage.sv
rtl/gf3_tower_inv.sv
dv/gf3_tower_inv_props.sv
dv/tb_gf3_tower_inv.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_gf3_tower_inv
FLIST = flist.f
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

obj_dir/V$(TOP): $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
